/* flist.f */
logic/fadd_fmt_pkg.sv
logic/fadd_op_pkg.sv
logic/fadd_src_classify.sv
logic/fadd_ex1_align.sv
logic/fadd_ex2_addsub.sv
logic/fadd_result_dp.sv
logic/fadd_pipe_top.sv
verification/fadd_tb.sv

/* logic/fadd_ex1_align.sv */
//=============================
// ex1 stage of the fp add pipeline
// swaps by magnitude, aligns the small mantissa, resolves specials and min/max
// registers the ex2 record on every clock
//=============================
`timescale 1ns/1ns
`default_nettype none

module fadd_ex1_align (
  input  logic                         fadd_ex1_pipe_clk,
  input  logic                         rst_n,
  input  logic                         in_vld,
  input  fadd_op_pkg::fadd_op_e        in_op,
  input  fadd_fmt_pkg::fadd_fmt_e      in_fmt,
  input  fadd_op_pkg::fadd_src_class_t src0_cls,
  input  fadd_op_pkg::fadd_src_class_t src1_cls,
  output logic                         ex2_vld,
  output fadd_op_pkg::fadd_ex2_t       ex2_data
);
  import fadd_fmt_pkg::*;
  import fadd_op_pkg::*;

  // quiet nan fraction, msb set only
  localparam logic [FADD_MAN_W-2:0] QNAN_FRAC = {1'b1, {(FADD_MAN_W-2){1'b0}}};

  fadd_ex2_t             ex1_data;
  fadd_src_class_t       src_big;
  fadd_src_class_t       src_sml;
  logic                  sign0;
  logic                  sign1;
  logic                  sign_l;
  logic                  op_minmax;
  logic                  src0_ge;
  logic                  mag_eq;
  logic                  src0_lt;
  logic                  src0_nan;
  logic                  src1_nan;
  logic                  inf_sub;
  logic [FADD_EXP_W-1:0] exp_diff;
  logic [31:0]           src0_int;
  logic [31:0]           src1_int;

  // subtract flips source 1
  assign sign0     = src0_cls.sign;
  assign sign1     = src1_cls.sign ^ (in_op == OP_SUB);
  assign op_minmax = (in_op == OP_MIN) || (in_op == OP_MAX);

  //=============================
  // magnitude order and alignment
  //=============================
  assign src0_ge  = {src0_cls.exp, src0_cls.man} >= {src1_cls.exp, src1_cls.man};
  assign mag_eq   = {src0_cls.exp, src0_cls.man} == {src1_cls.exp, src1_cls.man};
  assign src_big  = src0_ge ? src0_cls : src1_cls;
  assign src_sml  = src0_ge ? src1_cls : src0_cls;
  assign sign_l   = src0_ge ? sign0 : sign1;
  assign exp_diff = src_big.exp - src_sml.exp;

  // nan and inf flags
  assign src0_nan = src0_cls.qnan || src0_cls.snan;
  assign src1_nan = src1_cls.qnan || src1_cls.snan;
  assign inf_sub  = src0_cls.inf && src1_cls.inf && (sign0 ^ sign1);

  // operands in internal 32-bit form for min/max
  assign src0_int = {sign0, src0_cls.exp, src0_cls.man[FADD_MAN_W-2:0]};
  assign src1_int = {sign1, src1_cls.exp, src1_cls.man[FADD_MAN_W-2:0]};

  // signed order, negative side reverses magnitude
  assign src0_lt = (sign0 != sign1) ? sign0 :
                   sign0 ? (src0_ge && !mag_eq) : !src0_ge;

  always_comb begin
    ex1_data.fmt     = in_fmt;
    ex1_data.op      = in_op;
    ex1_data.eff_sub = sign0 ^ sign1;
    ex1_data.man_l   = src_big.man;
    // truncating shift, no guard or sticky
    ex1_data.man_s   = src_sml.man >> exp_diff;
    ex1_data.exp_l   = src_big.exp;
    ex1_data.sign_l  = sign_l;
    ex1_data.nv      = src0_cls.snan || src1_cls.snan || (!op_minmax && inf_sub);

    // default special is the quiet nan
    ex1_data.spec_vld  = 1'b0;
    ex1_data.spec_data = {1'b0, src_big.exp, QNAN_FRAC};
    ex1_data.sel_vld   = 1'b0;
    ex1_data.sel_data  = src0_int;

    if (op_minmax) begin
      if (src0_nan && src1_nan) begin
        ex1_data.spec_vld = 1'b1;
      end else begin
        ex1_data.sel_vld = 1'b1;
        if (src0_nan) begin
          ex1_data.sel_data = src1_int;
        end else if (src1_nan) begin
          ex1_data.sel_data = src0_int;
        end else if (src0_cls.zero && src1_cls.zero) begin
          // min prefers -0, max prefers +0
          ex1_data.sel_data = {(in_op == OP_MIN) ? (sign0 | sign1) : (sign0 & sign1), 31'b0};
        end else if ((in_op == OP_MIN) == src0_lt) begin
          ex1_data.sel_data = src0_int;
        end else begin
          ex1_data.sel_data = src1_int;
        end
      end
    end else if (src0_nan || src1_nan || inf_sub) begin
      ex1_data.spec_vld = 1'b1;
    end else if (src0_cls.inf || src1_cls.inf) begin
      // infinity sits in the big slot
      ex1_data.spec_vld  = 1'b1;
      ex1_data.spec_data = {sign_l, src_big.exp, {(FADD_MAN_W-1){1'b0}}};
    end
  end

  //=============================
  // ex1 to ex2
  //=============================
  always_ff @(posedge fadd_ex1_pipe_clk) begin
    if (!rst_n) begin
      ex2_vld <= 1'b0;
    end else begin
      ex2_vld <= in_vld;
    end
  end

  always_ff @(posedge fadd_ex1_pipe_clk) begin
    ex2_data <= ex1_data;
  end

  ex2_vld_rst_a: assert property (@(posedge fadd_ex1_pipe_clk) !rst_n |=> !ex2_vld);

  // one result source at most in ex2
  ex2_src_excl_a: assert property (@(posedge fadd_ex1_pipe_clk) disable iff (!rst_n)
    ex2_vld |-> !(ex2_data.spec_vld && ex2_data.sel_vld));

endmodule

`default_nettype wire

/* logic/fadd_ex2_addsub.sv */
//=============================
// ex2 mantissa add/sub with normalization
// combinational, feeds the result datapath in the same cycle
//=============================
`timescale 1ns/1ns
`default_nettype none

module fadd_ex2_addsub (
  input  fadd_op_pkg::fadd_ex2_t    ex2_data,
  output fadd_op_pkg::fadd_addsub_t ex2_sum
);
  import fadd_fmt_pkg::*;

  logic [FADD_MAN_W:0]   sum_raw;
  logic [4:0]            lz_cnt;
  logic [FADD_MAN_W-1:0] man_norm;
  logic signed [9:0]     exp_base;
  logic signed [9:0]     exp_norm;

  // large first, so the difference never goes negative
  always_comb begin
    if (ex2_data.eff_sub) begin
      sum_raw = {1'b0, ex2_data.man_l} - {1'b0, ex2_data.man_s};
    end else begin
      sum_raw = {1'b0, ex2_data.man_l} + {1'b0, ex2_data.man_s};
    end
  end

  //=============================
  // leading zero count
  //=============================
  // highest set bit wins, full width when all zero
  always_comb begin
    lz_cnt = 5'(FADD_MAN_W);
    for (int i = 0; i < FADD_MAN_W; i++) begin
      if (sum_raw[i]) begin
        lz_cnt = 5'(FADD_MAN_W - 1 - i);
      end
    end
  end

  assign exp_base = $signed({2'b00, ex2_data.exp_l});

  // carry out shifts right, dropped lsb is truncated
  // otherwise shift left by the zero count
  always_comb begin
    if (sum_raw[FADD_MAN_W]) begin
      man_norm = sum_raw[FADD_MAN_W:1];
      exp_norm = exp_base + 10'sd1;
    end else begin
      man_norm = sum_raw[FADD_MAN_W-1:0] << lz_cnt;
      exp_norm = exp_base - $signed({5'b00000, lz_cnt});
    end
  end

  // exact zero shows up as a zero mantissa
  assign ex2_sum.man  = man_norm;
  assign ex2_sum.exp  = exp_norm;
  assign ex2_sum.sign = ex2_data.sign_l;

endmodule

`default_nettype wire

/* logic/fadd_fmt_pkg.sv */
//=============================
// format definitions for the fp add pipeline
// covers ieee single, ieee half and bfloat16
// import inside a module body, use scoped names in headers
//=============================
`default_nettype none

package fadd_fmt_pkg;

  // operand format select
  typedef enum logic [1:0] {
    FMT_SINGLE = 2'd0,
    FMT_HALF   = 2'd1,
    FMT_BHALF  = 2'd2
  } fadd_fmt_e;

  // internal layout, sized for the widest format
  localparam int FADD_EXP_W = 8;
  // hidden bit included
  localparam int FADD_MAN_W = 24;

  // ieee single
  localparam int SGL_EXP_W    = 8;
  localparam int SGL_FRAC_W   = 23;
  localparam int SGL_EXP_MAX  = 255;

  // ieee half
  localparam int HALF_EXP_W   = 5;
  localparam int HALF_FRAC_W  = 10;
  localparam int HALF_EXP_MAX = 31;

  // bfloat16
  localparam int BHALF_EXP_W   = 8;
  localparam int BHALF_FRAC_W  = 7;
  localparam int BHALF_EXP_MAX = 255;

  // canonical quiet nan, right-aligned in 32 bits
  localparam logic [31:0] SGL_CNAN   = 32'h7fc0_0000;
  localparam logic [31:0] HALF_CNAN  = 32'h0000_7e00;
  localparam logic [31:0] BHALF_CNAN = 32'h0000_7fc0;

endpackage

`default_nettype wire

/* logic/fadd_op_pkg.sv */
//=============================
// opcodes and stage records of the fp add pipeline
// structs here travel between the classifier and the ex1/ex2/ex3 blocks
//=============================
`default_nettype none

package fadd_op_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MIN = 2'd2,
    OP_MAX = 2'd3
  } fadd_op_e;

  // one unpacked operand, internal layout
  typedef struct packed {
    logic                                sign;
    logic [fadd_fmt_pkg::FADD_EXP_W-1:0] exp;
    logic [fadd_fmt_pkg::FADD_MAN_W-1:0] man;
    logic                                zero;
    logic                                inf;
    logic                                qnan;
    logic                                snan;
  } fadd_src_class_t;

  // ex1 to ex2 record
  // spec_data and sel_data hold {sign, exp[7:0], frac[22:0]}
  typedef struct packed {
    fadd_fmt_pkg::fadd_fmt_e             fmt;
    fadd_op_e                            op;
    logic                                eff_sub;
    logic [fadd_fmt_pkg::FADD_MAN_W-1:0] man_l;
    logic [fadd_fmt_pkg::FADD_MAN_W-1:0] man_s;
    logic [fadd_fmt_pkg::FADD_EXP_W-1:0] exp_l;
    logic                                sign_l;
    logic                                spec_vld;
    logic [31:0]                         spec_data;
    logic                                sel_vld;
    logic [31:0]                         sel_data;
    logic                                nv;
  } fadd_ex2_t;

  // normalized add/sub result, exponent may leave the format range
  typedef struct packed {
    logic [fadd_fmt_pkg::FADD_MAN_W-1:0] man;
    logic signed [9:0]                   exp;
    logic                                sign;
  } fadd_addsub_t;

  // final result at ex3
  typedef struct packed {
    logic [31:0] data;
    logic        nv;
  } fadd_rslt_t;

endpackage

`default_nettype wire

/* logic/fadd_pipe_top.sv */
//=============================
// fp add pipeline top
// add, sub, min, max on single, half and bfloat16
// result valid two cycles after the input strobe
//=============================
`timescale 1ns/1ns
`default_nettype none

module fadd_pipe_top (
  input  logic                    fadd_ex1_pipe_clk,
  input  logic                    rst_n,
  input  logic                    in_vld,
  input  fadd_op_pkg::fadd_op_e   in_op,
  input  fadd_fmt_pkg::fadd_fmt_e in_fmt,
  input  logic [31:0]             in_src0,
  input  logic [31:0]             in_src1,
  output logic                    out_vld,
  output fadd_op_pkg::fadd_rslt_t out_rslt
);
  import fadd_op_pkg::*;

  fadd_src_class_t src0_cls;
  fadd_src_class_t src1_cls;
  logic            ex2_vld;
  fadd_ex2_t       ex2_data;
  fadd_addsub_t    ex2_sum;

  // ex1 operand unpack
  fadd_src_classify src0_cls0 (
    .fmt (in_fmt),
    .src (in_src0),
    .cls (src0_cls)
  );

  fadd_src_classify src1_cls0 (
    .fmt (in_fmt),
    .src (in_src1),
    .cls (src1_cls)
  );

  // ex1 align, registers into ex2
  fadd_ex1_align ex1_align0 (
    .fadd_ex1_pipe_clk (fadd_ex1_pipe_clk),
    .rst_n             (rst_n),
    .in_vld            (in_vld),
    .in_op             (in_op),
    .in_fmt            (in_fmt),
    .src0_cls          (src0_cls),
    .src1_cls          (src1_cls),
    .ex2_vld           (ex2_vld),
    .ex2_data          (ex2_data)
  );

  // ex2 mantissa arithmetic
  fadd_ex2_addsub ex2_addsub0 (
    .ex2_data (ex2_data),
    .ex2_sum  (ex2_sum)
  );

  // ex2 select and pack, registers into ex3
  fadd_result_dp result_dp0 (
    .fadd_ex1_pipe_clk (fadd_ex1_pipe_clk),
    .rst_n             (rst_n),
    .ex2_vld           (ex2_vld),
    .ex2_data          (ex2_data),
    .ex2_sum           (ex2_sum),
    .out_vld           (out_vld),
    .out_rslt          (out_rslt)
  );

endmodule

`default_nettype wire

/* logic/fadd_result_dp.sv */
//=============================
// ex2 result select and format packing
// priority is special, then min/max select, then add/sub
// registers result and invalid flag into ex3
//=============================
`timescale 1ns/1ns
`default_nettype none

module fadd_result_dp (
  input  logic                      fadd_ex1_pipe_clk,
  input  logic                      rst_n,
  input  logic                      ex2_vld,
  input  fadd_op_pkg::fadd_ex2_t    ex2_data,
  input  fadd_op_pkg::fadd_addsub_t ex2_sum,
  output logic                      out_vld,
  output fadd_op_pkg::fadd_rslt_t   out_rslt
);
  import fadd_fmt_pkg::*;

  localparam int FRAC_W = FADD_MAN_W - 1;

  logic [31:0]           pick_data;
  logic                  res_nan;
  logic signed [9:0]     exp_max;
  logic                  fin_sign;
  logic [FADD_EXP_W-1:0] fin_exp;
  logic [FRAC_W-1:0]     fin_frac;
  logic [31:0]           rslt_data;
  fadd_fmt_e             ex3_fmt;

  // exponent ceiling of the format
  always_comb begin
    case (ex2_data.fmt)
      FMT_HALF:  exp_max = 10'(HALF_EXP_MAX);
      FMT_BHALF: exp_max = 10'(BHALF_EXP_MAX);
      default:   exp_max = 10'(SGL_EXP_MAX);
    endcase
  end

  // special and select data already in range
  assign pick_data = ex2_data.spec_vld ? ex2_data.spec_data : ex2_data.sel_data;
  assign res_nan   = ex2_data.spec_vld && (ex2_data.spec_data[FRAC_W-1:0] != '0);

  //=============================
  // sign, exponent, fraction
  //=============================
  always_comb begin
    fin_sign = ex2_sum.sign;
    fin_exp  = ex2_sum.exp[FADD_EXP_W-1:0];
    fin_frac = ex2_sum.man[FRAC_W-1:0];
    if (ex2_data.spec_vld || ex2_data.sel_vld) begin
      fin_sign = pick_data[31];
      fin_exp  = pick_data[30:FRAC_W];
      fin_frac = pick_data[FRAC_W-1:0];
    end else if (ex2_sum.man == '0) begin
      // exact zero, -0 only from -0 + -0
      fin_sign = !ex2_data.eff_sub && ex2_sum.sign;
      fin_exp  = '0;
      fin_frac = '0;
    end else if (ex2_sum.exp <= 10'sd0) begin
      // underflow to signed zero
      fin_exp  = '0;
      fin_frac = '0;
    end else if (ex2_sum.exp >= exp_max) begin
      // round toward zero stops at max finite
      fin_exp  = FADD_EXP_W'(exp_max - 10'sd1);
      fin_frac = '1;
    end
  end

  // right-aligned pack, upper half zero for 16-bit formats
  always_comb begin
    case (ex2_data.fmt)
      FMT_HALF: begin
        rslt_data = res_nan ? HALF_CNAN :
                    {16'h0, fin_sign, fin_exp[HALF_EXP_W-1:0],
                     fin_frac[FRAC_W-1 -: HALF_FRAC_W]};
      end
      FMT_BHALF: begin
        rslt_data = res_nan ? BHALF_CNAN :
                    {16'h0, fin_sign, fin_exp[BHALF_EXP_W-1:0],
                     fin_frac[FRAC_W-1 -: BHALF_FRAC_W]};
      end
      default: begin
        rslt_data = res_nan ? SGL_CNAN :
                    {fin_sign, fin_exp[SGL_EXP_W-1:0], fin_frac[FRAC_W-1 -: SGL_FRAC_W]};
      end
    endcase
  end

  //=============================
  // ex2 to ex3
  //=============================
  always_ff @(posedge fadd_ex1_pipe_clk) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= ex2_vld;
    end
  end

  always_ff @(posedge fadd_ex1_pipe_clk) begin
    out_rslt.data <= rslt_data;
    out_rslt.nv   <= ex2_data.nv;
    ex3_fmt       <= ex2_data.fmt;
  end

  ex3_pad_a: assert property (@(posedge fadd_ex1_pipe_clk) disable iff (!rst_n)
    out_vld && (ex3_fmt == FMT_HALF || ex3_fmt == FMT_BHALF)
    |-> out_rslt.data[31:16] == 16'h0);

endmodule

`default_nettype wire

/* logic/fadd_src_classify.sv */
//=============================
// operand unpack and classify, combinational in ex1
// one instance per source operand
//=============================
`timescale 1ns/1ns
`default_nettype none

module fadd_src_classify (
  input  fadd_fmt_pkg::fadd_fmt_e      fmt,
  input  logic [31:0]                  src,
  output fadd_op_pkg::fadd_src_class_t cls
);
  import fadd_fmt_pkg::*;

  localparam int FRAC_W = FADD_MAN_W - 1;

  logic                  sign;
  logic [FADD_EXP_W-1:0] exp_f;
  logic [FRAC_W-1:0]     frac_f;
  logic [FADD_EXP_W-1:0] exp_max;
  logic                  exp_zero;
  logic                  exp_ones;

  // field select per format
  // fraction left-aligned under the hidden bit
  always_comb begin
    case (fmt)
      FMT_HALF: begin
        sign    = src[HALF_EXP_W + HALF_FRAC_W];
        exp_f   = FADD_EXP_W'(src[HALF_FRAC_W +: HALF_EXP_W]);
        frac_f  = FRAC_W'(src[HALF_FRAC_W-1:0]) << (FRAC_W - HALF_FRAC_W);
        exp_max = FADD_EXP_W'(HALF_EXP_MAX);
      end
      FMT_BHALF: begin
        sign    = src[BHALF_EXP_W + BHALF_FRAC_W];
        exp_f   = FADD_EXP_W'(src[BHALF_FRAC_W +: BHALF_EXP_W]);
        frac_f  = FRAC_W'(src[BHALF_FRAC_W-1:0]) << (FRAC_W - BHALF_FRAC_W);
        exp_max = FADD_EXP_W'(BHALF_EXP_MAX);
      end
      default: begin
        // single, also the unused encoding
        sign    = src[SGL_EXP_W + SGL_FRAC_W];
        exp_f   = FADD_EXP_W'(src[SGL_FRAC_W +: SGL_EXP_W]);
        frac_f  = FRAC_W'(src[SGL_FRAC_W-1:0]);
        exp_max = FADD_EXP_W'(SGL_EXP_MAX);
      end
    endcase
  end

  assign exp_zero = (exp_f == '0);
  assign exp_ones = (exp_f == exp_max);

  // subnormals flush to signed zero
  assign cls.sign = sign;
  assign cls.exp  = exp_zero ? '0 : exp_f;
  assign cls.man  = exp_zero ? '0 : {1'b1, frac_f};
  assign cls.zero = exp_zero;

  // all-ones exponent, msb of fraction splits quiet from signalling
  assign cls.inf  = exp_ones && (frac_f == '0);
  assign cls.qnan = exp_ones && frac_f[FRAC_W-1];
  assign cls.snan = exp_ones && !frac_f[FRAC_W-1] && (frac_f != '0);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the fp add pipeline testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module fadd_tb -Mdir obj_dir -f flist.f

out=$(./obj_dir/Vfadd_tb)
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

/* verification/fadd_input_vectors.txt */
# columns: op (0 add, 1 sub, 2 min, 3 max)  fmt (0 single, 1 half, 2 bfloat16)
# then src0  src1  expected result  expected invalid flag, all hex
0 0 3f800000 3f800000 40000000 0
0 0 3fffffff 3f800000 403fffff 0
1 0 3fc00000 3f800000 3f000000 0
0 0 3f800000 34400000 3f800001 0
1 0 3f800000 40000000 bf800000 0
0 1 00003c00 00003c00 00004000 0
1 1 00003e00 00003c00 00003800 0
0 2 00003f80 00003f80 00004000 0
1 2 00003fc0 00003f80 00003f00 0
0 2 00003f80 00003b80 00003f80 0
2 0 3f800000 c0000000 c0000000 0
3 0 3f800000 40000000 40000000 0
2 1 00007e00 00003c00 00003c00 0
3 2 00007fc0 00007fc1 00007fc0 0
2 0 00000000 80000000 80000000 0
3 1 00008000 00000000 00000000 0
2 2 0000c000 0000bf80 0000c000 0
0 0 7f800000 3f800000 7f800000 0
1 0 7f800000 7f800000 7fc00000 1
0 0 7f800001 3f800000 7fc00000 1
0 1 00007e01 00003c00 00007e00 0
1 2 0000ff80 00007f80 0000ff80 0
3 0 7f800001 3f800000 3f800000 1
1 0 3f800000 3f800000 00000000 0
0 0 80000000 80000000 80000000 0
0 0 00000001 3f800000 3f800000 0
0 1 00000001 00000001 00000000 0
1 0 00800000 00800001 80000000 0
0 0 7f7fffff 7f7fffff 7f7fffff 0
0 1 00007bff 00007bff 00007bff 0
0 2 0000ff7f 0000ff7f 0000ff7f 0

/* verification/fadd_tb.sv */
//=============================
// testbench for the fp add pipeline
// reads vectors from the data file, runs them back-to-back and then with gaps
// checks result, invalid flag and latency of every operation
//=============================
`timescale 1ns/1ns
`default_nettype none

module fadd_tb;
  import fadd_fmt_pkg::*;
  import fadd_op_pkg::*;

  // edges from the sampling edge to the result
  localparam int LATENCY = 2;
  localparam int DRAIN_LIMIT = 50;

  typedef struct {
    logic [1:0]  op;
    logic [1:0]  fmt;
    logic [31:0] src0;
    logic [31:0] src1;
    logic [31:0] rslt;
    logic        nv;
  } vec_t;

  typedef struct {
    int          idx;
    int          due;
    logic [31:0] data;
    logic        nv;
  } expect_t;

  logic        fadd_ex1_pipe_clk;
  logic        rst_n;
  logic        in_vld;
  fadd_op_e    in_op;
  fadd_fmt_e   in_fmt;
  logic [31:0] in_src0;
  logic [31:0] in_src1;
  logic        out_vld;
  fadd_rslt_t  out_rslt;

  vec_t        vecs[$];
  expect_t     expq[$];
  int          cyc;
  int          run_id;
  int          pass_cnt;
  int          fail_cnt;
  int          err_cnt;
  logic [31:0] lfsr_state;

  fadd_pipe_top dut0 (
    .fadd_ex1_pipe_clk (fadd_ex1_pipe_clk),
    .rst_n             (rst_n),
    .in_vld            (in_vld),
    .in_op             (in_op),
    .in_fmt            (in_fmt),
    .in_src0           (in_src0),
    .in_src1           (in_src1),
    .out_vld           (out_vld),
    .out_rslt          (out_rslt)
  );

  always #5 fadd_ex1_pipe_clk = ~fadd_ex1_pipe_clk;

  // edge counter, used for the latency check
  always @(posedge fadd_ex1_pipe_clk) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // right-shift galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // idle cycles between vectors, 3 bits so 0..7
  function automatic int take_gap();
    int g;
    g = 0;
    for (int b = 0; b < 3; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      g = (g << 1) | int'(lfsr_state[0]);
    end
    return g;
  endfunction

  task automatic compare_data(input fadd_rslt_t got, input logic [31:0] want,
                              input int idx, inout logic ok);
    if (got.data !== want) begin
      $display("FAIL @%0t: test %0d result %h, expected %h", $time, idx, got.data, want);
      ok = 1'b0;
    end
  endtask

  task automatic compare_nv(input fadd_rslt_t got, input logic want,
                            input int idx, inout logic ok);
    if (got.nv !== want) begin
      $display("FAIL @%0t: test %0d invalid flag %b, expected %b", $time, idx, got.nv, want);
      ok = 1'b0;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    vec_t        v;
    logic [31:0] f_op;
    logic [31:0] f_fmt;
    logic [31:0] f_nv;
    fd = $fopen("verification/fadd_input_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      err_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // comment and blank lines do not scan six fields
      if (n > 0 && $sscanf(line, "%h %h %h %h %h %h",
                           f_op, f_fmt, v.src0, v.src1, v.rslt, f_nv) == 6) begin
        v.op  = f_op[1:0];
        v.fmt = f_fmt[1:0];
        v.nv  = f_nv[0];
        vecs.push_back(v);
      end
    end
    $fclose(fd);
    if (vecs.size() == 0) begin
      $display("the vector file holds no vectors");
      err_cnt++;
    end
  endtask

  task automatic send_vector(input int i);
    expect_t e;
    in_vld  <= 1'b1;
    in_op   <= fadd_op_e'(vecs[i].op);
    in_fmt  <= fadd_fmt_e'(vecs[i].fmt);
    in_src0 <= vecs[i].src0;
    in_src1 <= vecs[i].src1;
    e.idx  = i;
    e.data = vecs[i].rslt;
    e.nv   = vecs[i].nv;
    // cyc still holds the count before this edge
    e.due  = cyc + 1 + LATENCY;
    expq.push_back(e);
  endtask

  task automatic run_vectors(input logic gapped);
    int gap;
    for (int i = 0; i < vecs.size(); i++) begin
      @(posedge fadd_ex1_pipe_clk);
      send_vector(i);
      gap = gapped ? take_gap() : 0;
      repeat (gap) begin
        @(posedge fadd_ex1_pipe_clk);
        in_vld <= 1'b0;
      end
    end
    @(posedge fadd_ex1_pipe_clk);
    in_vld <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (expq.size() != 0 && n < DRAIN_LIMIT) begin
      @(posedge fadd_ex1_pipe_clk);
      n++;
    end
    if (expq.size() != 0) begin
      $display("out_vld never arrived for %0d pending operations", expq.size());
      err_cnt++;
      expq.delete();
    end
  endtask

  //=============================
  // output checker, samples on the falling edge
  //=============================
  always @(negedge fadd_ex1_pipe_clk) begin : check_out
    expect_t e;
    logic    ok;
    if (!rst_n) begin
      if (out_vld) begin
        $display("out_vld was high during reset at %0t", $time);
        err_cnt++;
      end
    end else if (out_vld) begin
      if (expq.size() == 0) begin
        $display("out_vld rose with no operation in flight at %0t", $time);
        err_cnt++;
      end else begin
        e  = expq.pop_front();
        ok = 1'b1;
        if (cyc != e.due) begin
          $display("FAIL @%0t: test %0d out_vld at cycle %0d, expected %0d",
                   $time, e.idx, cyc, e.due);
          ok = 1'b0;
        end
        compare_data(out_rslt, e.data, e.idx, ok);
        compare_nv(out_rslt, e.nv, e.idx, ok);
        if (ok) begin
          pass_cnt++;
        end else begin
          fail_cnt++;
        end
        $display("test %0d run %0d: %s", e.idx, run_id, ok ? "ok" : "mismatch");
      end
    end
  end

  initial begin
    fadd_ex1_pipe_clk = 1'b0;
    rst_n      = 1'b0;
    // strobes held high through reset, none may reach out_vld
    in_vld     = 1'b1;
    in_op      = OP_ADD;
    in_fmt     = FMT_SINGLE;
    in_src0    = '0;
    in_src1    = '0;
    run_id     = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    err_cnt    = 0;
    lfsr_state = 32'h1add_b280;
    load_vectors();
    repeat (8) @(posedge fadd_ex1_pipe_clk);
    rst_n  <= 1'b1;
    in_vld <= 1'b0;
    // quiet cycles, checker flags any stray out_vld
    repeat (3) @(posedge fadd_ex1_pipe_clk);
    run_vectors(1'b0);
    wait_drain();
    run_id = 1;
    run_vectors(1'b1);
    wait_drain();
    repeat (4) @(posedge fadd_ex1_pipe_clk);
    $display("checks done: %0d passed, %0d failed, %0d other errors",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
